// ==== eink_pixel.f ====
rtl/eink_pixel_pkg.sv
rtl/pixel_intake.sv
rtl/waveform_step.sv
rtl/mode_override.sv
rtl/result_sender.sv
rtl/eink_pixel_top.sv
testbench/pixel_asserts.sv
testbench/pixel_checker.sv
testbench/tb_top.sv

// ==== rtl/eink_pixel_pkg.sv ====
package eink_pixel_pkg;

    // Pixel state word from video memory
    // Mode 15..12, stage 11..10, frame counter 9..4, previous value 3..0
    typedef logic [15:0] pixel_state_t;
    // Pixel value, bit 3 set means light
    typedef logic [3:0]  pixel_t;
    // Per-pixel frame counter
    typedef logic [5:0]  frame_cnt_t;
    // Global operation frame counter
    typedef logic [10:0] op_frame_t;
    // Panel drive code
    typedef logic [1:0]  drive_t;
    typedef logic [7:0]  op_cmd_t;
    typedef logic [7:0]  op_param_t;
    // Controller operating state
    typedef logic [1:0]  op_state_t;

    // Fast grey stages held in state bits 11..10
    typedef enum logic [1:0] {
        stage_done = 2'd0,
        stage_mono = 2'd1,
        stage_hold = 2'd2,
        stage_grey = 2'd3
    } grey_stage_e;

    // Mode field values
    localparam logic [3:0] MODE_FAST_MONO = 4'd8;
    localparam logic [3:0] MODE_FAST_GREY = 4'd11;

    // Drive codes
    localparam drive_t DRIVE_NONE  = 2'd0;
    localparam drive_t DRIVE_BLACK = 2'd1;
    localparam drive_t DRIVE_WHITE = 2'd2;

    // External operation command and controller state
    localparam op_cmd_t   OP_EXT_SETMODE = 8'd1;
    localparam op_state_t OP_INIT        = 2'd1;

    // Set-mode parameters that are kept
    localparam op_param_t SETMODE_FAST_MONO = 8'd2;
    localparam op_param_t SETMODE_FAST_GREY = 8'd5;

    // Fast mono transition lengths
    localparam frame_cnt_t FASTM_B2W_FRAMES = 6'd10;
    localparam frame_cnt_t FASTM_W2B_FRAMES = 6'd10;

    // Fast grey lengths
    localparam frame_cnt_t FASTG_HOLDOFF_FRAMES = 6'd10;
    localparam frame_cnt_t FASTG_B2G_FRAMES     = 6'd1;
    localparam frame_cnt_t FASTG_W2G_FRAMES     = 6'd1;
    localparam frame_cnt_t FASTG_LG2B_FRAMES    = 6'd8;
    localparam frame_cnt_t FASTG_DG2B_FRAMES    = 6'd5;
    localparam frame_cnt_t FASTG_LG2W_FRAMES    = 6'd5;
    localparam frame_cnt_t FASTG_DG2W_FRAMES    = 6'd8;

    // Fast mono, idle, previous value white
    localparam pixel_state_t INITIAL_STATE = {MODE_FAST_MONO, 2'b00, 6'd0, 4'd1};
    // Fast grey, settled, previous value 3
    localparam pixel_state_t SETMODE_GREY_STATE = {MODE_FAST_GREY, stage_done, 6'd0, 4'd3};

    // Input forced in during a set-mode clear
    localparam pixel_t CLEAR_PIXEL = 4'd3;

endpackage

// ==== rtl/eink_pixel_top.sv ====
module eink_pixel_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_req,
    input  eink_pixel_pkg::pixel_state_t  in_state,
    input  eink_pixel_pkg::pixel_t        in_pixel,
    input  logic                          op_valid,
    input  eink_pixel_pkg::op_cmd_t       op_cmd,
    input  eink_pixel_pkg::op_param_t     op_param,
    input  eink_pixel_pkg::op_state_t     op_state,
    input  eink_pixel_pkg::op_frame_t     op_framecnt,
    output logic                          in_ack,
    output logic                          out_req,
    input  logic                          out_ack,
    output eink_pixel_pkg::pixel_state_t  out_state,
    output eink_pixel_pkg::drive_t        out_drive
);

    // Stage 1, captured item
    logic                         s1_valid;
    logic                         s1_stall;
    eink_pixel_pkg::pixel_state_t s1_state;
    eink_pixel_pkg::pixel_t       s1_pixel;
    logic                         s1_set_apply;
    logic                         s1_set_clear;
    eink_pixel_pkg::op_param_t    s1_op_param;
    logic                         s1_init;
    eink_pixel_pkg::op_frame_t    s1_op_framecnt;
    // Stage 2, waveform result
    logic                         s2_valid;
    logic                         s2_stall;
    eink_pixel_pkg::pixel_state_t s2_state;
    eink_pixel_pkg::drive_t       s2_drive;
    logic                         s2_set_apply;
    eink_pixel_pkg::op_param_t    s2_op_param;
    logic                         s2_init;
    eink_pixel_pkg::op_frame_t    s2_op_framecnt;
    // Stage 3, final result
    logic                         s3_valid;
    logic                         s3_stall;
    eink_pixel_pkg::pixel_state_t s3_state;
    eink_pixel_pkg::drive_t       s3_drive;

    pixel_intake u_intake (
        .clk(clk), .reset(reset), .in_req(in_req), .in_state(in_state),
        .in_pixel(in_pixel), .op_valid(op_valid), .op_cmd(op_cmd), .op_param(op_param),
        .op_state(op_state), .op_framecnt(op_framecnt), .in_ack(in_ack),
        .s1_valid(s1_valid), .s1_state(s1_state), .s1_pixel(s1_pixel),
        .s1_set_apply(s1_set_apply), .s1_set_clear(s1_set_clear),
        .s1_op_param(s1_op_param), .s1_init(s1_init),
        .s1_op_framecnt(s1_op_framecnt), .s1_stall(s1_stall)
    );

    waveform_step u_waveform (
        .clk(clk), .reset(reset), .s1_valid(s1_valid), .s1_state(s1_state),
        .s1_pixel(s1_pixel), .s1_set_apply(s1_set_apply), .s1_set_clear(s1_set_clear),
        .s1_op_param(s1_op_param), .s1_init(s1_init), .s1_op_framecnt(s1_op_framecnt),
        .s1_stall(s1_stall), .s2_valid(s2_valid), .s2_state(s2_state),
        .s2_drive(s2_drive), .s2_set_apply(s2_set_apply), .s2_op_param(s2_op_param),
        .s2_init(s2_init), .s2_op_framecnt(s2_op_framecnt), .s2_stall(s2_stall)
    );

    mode_override u_override (
        .clk(clk), .reset(reset), .s2_valid(s2_valid), .s2_state(s2_state),
        .s2_drive(s2_drive), .s2_set_apply(s2_set_apply), .s2_op_param(s2_op_param),
        .s2_init(s2_init), .s2_op_framecnt(s2_op_framecnt), .s2_stall(s2_stall),
        .s3_valid(s3_valid), .s3_state(s3_state), .s3_drive(s3_drive),
        .s3_stall(s3_stall)
    );

    result_sender u_sender (
        .clk(clk), .reset(reset), .s3_valid(s3_valid), .s3_state(s3_state),
        .s3_drive(s3_drive), .s3_stall(s3_stall), .out_req(out_req),
        .out_ack(out_ack), .out_state(out_state), .out_drive(out_drive)
    );

endmodule

// ==== rtl/mode_override.sv ====
module mode_override (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          s2_valid,
    input  eink_pixel_pkg::pixel_state_t  s2_state,
    input  eink_pixel_pkg::drive_t        s2_drive,
    input  logic                          s2_set_apply,
    input  eink_pixel_pkg::op_param_t     s2_op_param,
    input  logic                          s2_init,
    input  eink_pixel_pkg::op_frame_t     s2_op_framecnt,
    output logic                          s2_stall,
    output logic                          s3_valid,
    output eink_pixel_pkg::pixel_state_t  s3_state,
    output eink_pixel_pkg::drive_t        s3_drive,
    input  logic                          s3_stall
);

    eink_pixel_pkg::pixel_state_t nxt_state;
    eink_pixel_pkg::drive_t       nxt_drive;
    logic                         load;

    always_comb begin
        nxt_state = s2_state;
        nxt_drive = s2_drive;
        // Set-mode apply loads the preset, unknown params get the initial state
        if (s2_set_apply) begin
            case (s2_op_param)
                eink_pixel_pkg::SETMODE_FAST_MONO: nxt_state = eink_pixel_pkg::INITIAL_STATE;
                eink_pixel_pkg::SETMODE_FAST_GREY: nxt_state = eink_pixel_pkg::SETMODE_GREY_STATE;
                default:                           nxt_state = eink_pixel_pkg::INITIAL_STATE;
            endcase
        end
        // Init pattern over a 128 frame round
        // 0..7 and 64..71 idle, then black in the low half, white in the high half
        if (s2_init) begin
            nxt_state = eink_pixel_pkg::INITIAL_STATE;
            if (s2_op_framecnt[5:3] == 3'b000) begin
                nxt_drive = eink_pixel_pkg::DRIVE_NONE;
            end else if (!s2_op_framecnt[6]) begin
                nxt_drive = eink_pixel_pkg::DRIVE_BLACK;
            end else begin
                nxt_drive = eink_pixel_pkg::DRIVE_WHITE;
            end
        end
    end

    assign load     = !s3_valid || !s3_stall;
    assign s2_stall = s3_valid && s3_stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            s3_valid <= 1'b0;
        end else if (load) begin
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load && s2_valid) begin
            s3_state <= nxt_state;
            s3_drive <= nxt_drive;
        end
    end

endmodule

// ==== rtl/pixel_intake.sv ====
module pixel_intake (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_req,
    input  eink_pixel_pkg::pixel_state_t  in_state,
    input  eink_pixel_pkg::pixel_t        in_pixel,
    input  logic                          op_valid,
    input  eink_pixel_pkg::op_cmd_t       op_cmd,
    input  eink_pixel_pkg::op_param_t     op_param,
    input  eink_pixel_pkg::op_state_t     op_state,
    input  eink_pixel_pkg::op_frame_t     op_framecnt,
    output logic                          in_ack,
    output logic                          s1_valid,
    output eink_pixel_pkg::pixel_state_t  s1_state,
    output eink_pixel_pkg::pixel_t        s1_pixel,
    output logic                          s1_set_apply,
    output logic                          s1_set_clear,
    output eink_pixel_pkg::op_param_t     s1_op_param,
    output logic                          s1_init,
    output eink_pixel_pkg::op_frame_t     s1_op_framecnt,
    input  logic                          s1_stall
);

    // Four-phase receiver
    typedef enum logic {
        rx_idle,
        rx_ack
    } rx_state_e;

    rx_state_e rx_state;
    logic      s1_free;
    logic      take;
    logic      set_mode;
    logic      set_clear;

    // Register can take a new item when empty or draining
    assign s1_free = !s1_valid || !s1_stall;
    assign take    = (rx_state == rx_idle) && in_req && s1_free;
    assign in_ack  = (rx_state == rx_ack);

    // Set-mode with a running frame counter is the clear pass
    assign set_mode  = op_valid && (op_cmd == eink_pixel_pkg::OP_EXT_SETMODE);
    assign set_clear = set_mode && (op_framecnt != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_state <= rx_idle;
            s1_valid <= 1'b0;
        end else begin
            case (rx_state)
                rx_idle: if (take) rx_state <= rx_ack;
                // Hold ack until the source drops its request
                rx_ack:  if (!in_req) rx_state <= rx_idle;
                default: rx_state <= rx_idle;
            endcase
            if (take) begin
                s1_valid <= 1'b1;
            end else if (!s1_stall) begin
                s1_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            s1_state       <= in_state;
            s1_pixel       <= set_clear ? eink_pixel_pkg::CLEAR_PIXEL : in_pixel;
            s1_set_apply   <= set_mode && (op_framecnt == '0);
            s1_set_clear   <= set_clear;
            s1_op_param    <= op_param;
            s1_init        <= (op_state == eink_pixel_pkg::OP_INIT);
            s1_op_framecnt <= op_framecnt;
        end
    end

endmodule

// ==== rtl/result_sender.sv ====
module result_sender (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          s3_valid,
    input  eink_pixel_pkg::pixel_state_t  s3_state,
    input  eink_pixel_pkg::drive_t        s3_drive,
    output logic                          s3_stall,
    output logic                          out_req,
    input  logic                          out_ack,
    output eink_pixel_pkg::pixel_state_t  out_state,
    output eink_pixel_pkg::drive_t        out_drive
);

    // Four-phase sender
    typedef enum logic [1:0] {
        tx_empty,
        tx_load,
        tx_req,
        tx_release
    } tx_state_e;

    tx_state_e tx_state;

    assign out_req  = (tx_state == tx_req);
    // Busy from load until the sink has dropped its ack
    assign s3_stall = (tx_state != tx_empty);

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_state  <= tx_empty;
            out_state <= '0;
            out_drive <= eink_pixel_pkg::DRIVE_NONE;
        end else begin
            case (tx_state)
                tx_empty: begin
                    if (s3_valid) begin
                        tx_state  <= tx_load;
                        out_state <= s3_state;
                        out_drive <= s3_drive;
                    end
                end
                // Data settles one cycle before the request
                tx_load:    tx_state <= tx_req;
                tx_req:     if (out_ack) tx_state <= tx_release;
                tx_release: if (!out_ack) tx_state <= tx_empty;
                default:    tx_state <= tx_empty;
            endcase
        end
    end

endmodule

// ==== rtl/waveform_step.sv ====
module waveform_step (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          s1_valid,
    input  eink_pixel_pkg::pixel_state_t  s1_state,
    input  eink_pixel_pkg::pixel_t        s1_pixel,
    input  logic                          s1_set_apply,
    input  logic                          s1_set_clear,
    input  eink_pixel_pkg::op_param_t     s1_op_param,
    input  logic                          s1_init,
    input  eink_pixel_pkg::op_frame_t     s1_op_framecnt,
    output logic                          s1_stall,
    output logic                          s2_valid,
    output eink_pixel_pkg::pixel_state_t  s2_state,
    output eink_pixel_pkg::drive_t        s2_drive,
    output logic                          s2_set_apply,
    output eink_pixel_pkg::op_param_t     s2_op_param,
    output logic                          s2_init,
    output eink_pixel_pkg::op_frame_t     s2_op_framecnt,
    input  logic                          s2_stall
);

    eink_pixel_pkg::grey_stage_e  stage;
    eink_pixel_pkg::frame_cnt_t   cnt;
    eink_pixel_pkg::frame_cnt_t   cnt_dec;
    eink_pixel_pkg::frame_cnt_t   cnt_turn;
    eink_pixel_pkg::pixel_t       prev;
    eink_pixel_pkg::pixel_t       vin;
    eink_pixel_pkg::drive_t       drive_in;
    eink_pixel_pkg::pixel_state_t nxt_state;
    eink_pixel_pkg::drive_t       nxt_drive;
    logic                         is_grey;
    logic                         load;

    // Field split of the state word
    assign stage   = eink_pixel_pkg::grey_stage_e'(s1_state[11:10]);
    assign cnt     = s1_state[9:4];
    assign prev    = s1_state[3:0];
    assign cnt_dec = cnt - 6'd1;
    // Input pixel, already the clear pixel on a clear pass
    assign vin      = s1_pixel;
    assign drive_in = vin[3] ? eink_pixel_pkg::DRIVE_WHITE : eink_pixel_pkg::DRIVE_BLACK;
    // Reversal mid-transition mirrors the count
    assign cnt_turn = vin[3] ? (eink_pixel_pkg::FASTM_B2W_FRAMES - cnt + 6'd2)
                             : (eink_pixel_pkg::FASTM_W2B_FRAMES - cnt + 6'd2);

    // Unknown modes fall back to fast mono
    assign is_grey = (s1_state[15:12] == eink_pixel_pkg::MODE_FAST_GREY);

    always_comb begin
        nxt_state = s1_state;
        nxt_drive = eink_pixel_pkg::DRIVE_NONE;
        if (!is_grey) begin
            // Fast mono, cancellable
            if (vin[3] != prev[0]) begin
                nxt_drive = drive_in;
                if (cnt != '0) begin
                    nxt_state = {s1_state[15:10], cnt_turn, 3'b000, vin[3]};
                end else begin
                    nxt_state = {s1_state[15:10], eink_pixel_pkg::FASTM_B2W_FRAMES, 3'b000, vin[3]};
                end
            end else if (cnt != '0) begin
                nxt_drive = drive_in;
                nxt_state = {s1_state[15:10], cnt_dec, prev};
            end
        end else if ((stage == eink_pixel_pkg::stage_done) ||
                     (stage == eink_pixel_pkg::stage_hold)) begin
            if (vin[3:2] != prev[1:0]) begin
                // New target, start the mono stage from the table
                nxt_drive = drive_in;
                case ({vin[3], prev[1:0]})
                    3'b110:  nxt_state[9:4] = eink_pixel_pkg::FASTG_LG2W_FRAMES;
                    3'b101:  nxt_state[9:4] = eink_pixel_pkg::FASTG_DG2W_FRAMES;
                    3'b010:  nxt_state[9:4] = eink_pixel_pkg::FASTG_LG2B_FRAMES;
                    3'b001:  nxt_state[9:4] = eink_pixel_pkg::FASTG_DG2B_FRAMES;
                    default: nxt_state[9:4] = eink_pixel_pkg::FASTM_B2W_FRAMES;
                endcase
                nxt_state[11:10] = eink_pixel_pkg::stage_mono;
                nxt_state[3:0]   = {2'b00, vin[3:2]};
            end else if (stage == eink_pixel_pkg::stage_hold) begin
                if (cnt != '0) begin
                    nxt_state[9:4] = cnt_dec;
                end else if (prev[1:0] == 2'b10) begin
                    nxt_state = {s1_state[15:12], eink_pixel_pkg::stage_grey,
                                 eink_pixel_pkg::FASTG_W2G_FRAMES, prev};
                end else if (prev[1:0] == 2'b01) begin
                    nxt_state = {s1_state[15:12], eink_pixel_pkg::stage_grey,
                                 eink_pixel_pkg::FASTG_B2G_FRAMES, prev};
                end else begin
                    // Pure black or white needs no grey pass
                    nxt_state = {s1_state[15:12], eink_pixel_pkg::stage_done, 6'd0, 2'b00, vin[3:2]};
                end
            end
        end else if (stage == eink_pixel_pkg::stage_mono) begin
            nxt_drive = drive_in;
            if (vin[3:2] != prev[1:0]) begin
                nxt_state = {s1_state[15:12], eink_pixel_pkg::stage_mono, cnt_turn, 2'b00, vin[3:2]};
            end else if (cnt == '0) begin
                nxt_state = {s1_state[15:12], eink_pixel_pkg::stage_hold,
                             eink_pixel_pkg::FASTG_HOLDOFF_FRAMES, prev};
            end else begin
                nxt_state[9:4] = cnt_dec;
            end
        end else begin
            // Grey stage ignores the input and drives back from the old value
            nxt_drive = prev[1] ? eink_pixel_pkg::DRIVE_BLACK : eink_pixel_pkg::DRIVE_WHITE;
            if (cnt == '0) begin
                nxt_state = {s1_state[15:12], eink_pixel_pkg::stage_done, 6'd0, prev};
            end else begin
                nxt_state[9:4] = cnt_dec;
            end
        end
    end

    assign load     = !s2_valid || !s2_stall;
    assign s1_stall = s2_valid && s2_stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else if (load) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load && s1_valid) begin
            s2_state       <= nxt_state;
            s2_drive       <= nxt_drive;
            s2_set_apply   <= s1_set_apply;
            s2_op_param    <= s1_op_param;
            s2_init        <= s1_init;
            s2_op_framecnt <= s1_op_framecnt;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pixel pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_top -f eink_pixel.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== testbench/pixel_asserts.sv ====
module pixel_asserts (
    input logic                         clk,
    input logic                         reset,
    input logic                         in_ack,
    input logic                         out_req,
    input logic                         out_ack,
    input eink_pixel_pkg::pixel_state_t out_state
);

    // Failures seen so far, read by the testbench top
    int fail_count = 0;

    // Both handshake outputs come out of reset low
    reset_clears: assert property (@(posedge clk) reset |=> (!in_ack && !out_req))
        else begin
            $error("in_ack or out_req high in the cycle after reset");
            fail_count++;
        end

    // Request is held until the sink acknowledges
    req_held: assert property (@(posedge clk) disable iff (reset)
        (out_req && !out_ack) |=> out_req)
        else begin
            $error("out_req dropped before out_ack rose");
            fail_count++;
        end

    // Result word frozen while offered
    state_stable: assert property (@(posedge clk) disable iff (reset)
        out_req |=> $stable(out_state))
        else begin
            $error("out_state changed while out_req was high");
            fail_count++;
        end

endmodule

// ==== testbench/pixel_checker.sv ====
module pixel_checker (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         out_req,
    input  eink_pixel_pkg::pixel_state_t out_state,
    input  eink_pixel_pkg::drive_t       out_drive,
    input  logic                         exp_push,
    input  eink_pixel_pkg::pixel_state_t exp_state,
    input  eink_pixel_pkg::drive_t       exp_drive,
    input  logic                         report,
    input  int                           assert_errors,
    output int                           seen_count,
    output int                           error_count
);

    // Expected results in launch order, state in 17..2, drive in 1..0
    logic [17:0] exp_q[$];
    logic [17:0] head;
    logic        req_q;

    initial begin
        seen_count  = 0;
        error_count = 0;
        req_q       = 1'b0;
    end

    always @(posedge clk) begin
        if (reset) begin
            req_q <= 1'b0;
        end else begin
            if (exp_push) begin
                exp_q.push_back({exp_state, exp_drive});
            end
            // New result offered on the rising request
            if (out_req && !req_q) begin
                if (exp_q.size() == 0) begin
                    $display("Result at time %0t arrived with none expected", $time);
                    error_count++;
                end else begin
                    head = exp_q.pop_front();
                    seen_count++;
                    if (out_state !== head[17:2]) begin
                        $display("CHECK FAILED time %0t out_state expected %h actual %h",
                                 $time, head[17:2], out_state);
                        error_count++;
                    end
                    if (out_drive !== head[1:0]) begin
                        $display("CHECK FAILED time %0t out_drive expected %0d actual %0d",
                                 $time, head[1:0], out_drive);
                        error_count++;
                    end
                end
            end
            req_q <= out_req;
        end
    end

    // Summary of the run
    always @(posedge report) begin
        $display("Errors: %0d check, %0d assertion; results checked: %0d",
                 error_count, assert_errors, seen_count);
    end

endmodule

// ==== testbench/tb_top.sv ====
module tb_top;

    // One stimulus record with its expected result
    typedef struct packed {
        eink_pixel_pkg::pixel_state_t state;
        eink_pixel_pkg::pixel_t       pixel;
        logic                         op_valid;
        eink_pixel_pkg::op_cmd_t      cmd;
        eink_pixel_pkg::op_param_t    param;
        eink_pixel_pkg::op_state_t    op_state;
        eink_pixel_pkg::op_frame_t    framecnt;
        eink_pixel_pkg::pixel_state_t exp_state;
        eink_pixel_pkg::drive_t       exp_drive;
    } vec_t;

    logic clk = 1'b0;
    logic reset;
    logic in_req;
    logic in_ack;
    logic out_req;
    logic out_ack;
    logic op_valid;
    logic exp_push;
    logic report;
    int   seen_count;
    int   error_count;
    int   ack_delay;
    logic [7:0] lfsr_state = 8'd36;
    eink_pixel_pkg::pixel_state_t in_state;
    eink_pixel_pkg::pixel_t       in_pixel;
    eink_pixel_pkg::op_cmd_t      op_cmd;
    eink_pixel_pkg::op_param_t    op_param;
    eink_pixel_pkg::op_state_t    op_state;
    eink_pixel_pkg::op_frame_t    op_framecnt;
    eink_pixel_pkg::pixel_state_t out_state;
    eink_pixel_pkg::drive_t       out_drive;
    eink_pixel_pkg::pixel_state_t exp_state;
    eink_pixel_pkg::drive_t       exp_drive;
    vec_t vecs[14];

    always #20 clk = ~clk;

    eink_pixel_top u_dut (
        .clk(clk), .reset(reset), .in_req(in_req), .in_state(in_state),
        .in_pixel(in_pixel), .op_valid(op_valid), .op_cmd(op_cmd), .op_param(op_param),
        .op_state(op_state), .op_framecnt(op_framecnt), .in_ack(in_ack),
        .out_req(out_req), .out_ack(out_ack), .out_state(out_state), .out_drive(out_drive)
    );

    bind eink_pixel_top pixel_asserts u_asserts (
        .clk(clk), .reset(reset), .in_ack(in_ack), .out_req(out_req),
        .out_ack(out_ack), .out_state(out_state)
    );

    pixel_checker u_checker (
        .clk(clk), .reset(reset), .out_req(out_req), .out_state(out_state),
        .out_drive(out_drive), .exp_push(exp_push), .exp_state(exp_state),
        .exp_drive(exp_drive), .report(report),
        .assert_errors(u_dut.u_asserts.fail_count),
        .seen_count(seen_count), .error_count(error_count)
    );

    // Galois LFSR, taps x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Four-phase send of one record, entered and left on a falling edge
    task automatic send_item(input vec_t v);
        in_state    = v.state;
        in_pixel    = v.pixel;
        op_valid    = v.op_valid;
        op_cmd      = v.cmd;
        op_param    = v.param;
        op_state    = v.op_state;
        op_framecnt = v.framecnt;
        in_req      = 1'b1;
        exp_state   = v.exp_state;
        exp_drive   = v.exp_drive;
        exp_push    = 1'b1;
        @(negedge clk);
        exp_push = 1'b0;
        while (!in_ack) @(negedge clk);
        in_req = 1'b0;
        @(negedge clk);
        while (in_ack) @(negedge clk);
    endtask

    initial begin
        // Fast mono, idle black to white, reversal, countdown, unknown mode
        vecs[0]  = '{16'h8000, 4'h8, 1'b0, 8'd0, 8'd0, 2'd0, 11'd0, 16'h80A1, 2'd2};
        vecs[1]  = '{16'h8041, 4'h0, 1'b0, 8'd0, 8'd0, 2'd0, 11'd0, 16'h8080, 2'd1};
        vecs[2]  = '{16'h8031, 4'hF, 1'b0, 8'd0, 8'd0, 2'd0, 11'd0, 16'h8021, 2'd2};
        vecs[3]  = '{16'h0000, 4'h8, 1'b0, 8'd0, 8'd0, 2'd0, 11'd0, 16'h00A1, 2'd2};
        // Fast grey through mono, hold, grey and done
        vecs[4]  = '{16'hB002, 4'hC, 1'b0, 8'd0, 8'd0, 2'd0, 11'd0, 16'hB453, 2'd2};
        vecs[5]  = '{16'hB403, 4'hC, 1'b0, 8'd0, 8'd0, 2'd0, 11'd0, 16'hB8A3, 2'd2};
        vecs[6]  = '{16'hB801, 4'h4, 1'b0, 8'd0, 8'd0, 2'd0, 11'd0, 16'hBC11, 2'd0};
        vecs[7]  = '{16'hBC01, 4'h4, 1'b0, 8'd0, 8'd0, 2'd0, 11'd0, 16'hB001, 2'd2};
        // Set-mode apply grey, apply unknown, clear pass
        vecs[8]  = '{16'h8000, 4'h0, 1'b1, 8'd1, 8'd5, 2'd0, 11'd0, 16'hB003, 2'd0};
        vecs[9]  = '{16'h8000, 4'h0, 1'b1, 8'd1, 8'd7, 2'd0, 11'd0, 16'h8001, 2'd0};
        vecs[10] = '{16'h8001, 4'hF, 1'b1, 8'd1, 8'd5, 2'd0, 11'd3, 16'h80A0, 2'd1};
        // Init pattern, idle then black then white
        vecs[11] = '{16'h8000, 4'h8, 1'b0, 8'd0, 8'd0, 2'd1, 11'd2, 16'h8001, 2'd0};
        vecs[12] = '{16'h8000, 4'h8, 1'b0, 8'd0, 8'd0, 2'd1, 11'd20, 16'h8001, 2'd1};
        vecs[13] = '{16'h8000, 4'h8, 1'b0, 8'd0, 8'd0, 2'd1, 11'd80, 16'h8001, 2'd2};

        reset       = 1'b1;
        in_req      = 1'b0;
        in_state    = '0;
        in_pixel    = '0;
        op_valid    = 1'b0;
        op_cmd      = '0;
        op_param    = '0;
        op_state    = '0;
        op_framecnt = '0;
        exp_push    = 1'b0;
        exp_state   = '0;
        exp_drive   = '0;
        report      = 1'b0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        // Quiet period, the checker flags any stray result
        repeat (8) @(negedge clk);
        for (int i = 0; i < $size(vecs); i++) begin
            send_item(vecs[i]);
        end
        while (seen_count < $size(vecs)) @(negedge clk);
        repeat (4) @(negedge clk);
        report = 1'b1;
        #1;
        if ((error_count + u_dut.u_asserts.fail_count) == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Sink side, acks after a random 0 to 7 cycle delay
    initial begin
        out_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (out_req && !out_ack) begin
                take_bits(3, ack_delay);
                repeat (ack_delay) @(negedge clk);
                out_ack = 1'b1;
                while (out_req) @(negedge clk);
                out_ack = 1'b0;
            end
        end
    end

    // Watchdog sized from the table length
    initial begin
        #(($size(vecs) * 40 + 10) * 40);
        $display("Timeout: run did not finish, %0d of %0d results seen, %0d errors",
                 seen_count, $size(vecs), error_count);
        $display("sim failed");
        $finish;
    end

endmodule
